/* source/road_pkg.sv */
//**********************************************************
// Shared game constants, AXI4-Lite register map,
// coordinate and state types, bus and config structs
//**********************************************************
`default_nettype none

package road_pkg;

    // Grid geometry and start cell
    localparam int NUM_CARS     = 4;
    localparam int GRID_W       = 40;        // Valid X is 0..GRID_W-1
    localparam int GRID_H       = 16;        // Rows
    localparam int GOAL_ROW     = 0;         // Frog target row
    localparam int FROG_START_X = 20;
    localparam int FROG_START_Y = 15;
    localparam int PERIOD_RESET = 1000;      // Tick period after reset

    // Field widths
    localparam int COORD_W     = 6;
    localparam int SPEED_W     = 2;
    localparam int PERIOD_W    = 24;
    localparam int CAR_VEC_W   = NUM_CARS * COORD_W;  // Packed positions, car 0 lowest
    localparam int SPD_VEC_W   = NUM_CARS * SPEED_W;
    localparam int AXI_ADDR_W  = 8;
    localparam int AXI_DATA_W  = 32;

    // Register byte offsets
    localparam logic [AXI_ADDR_W-1:0] REG_CTRL   = 8'h00;  // Bit 0 starts the game
    localparam logic [AXI_ADDR_W-1:0] REG_PERIOD = 8'h04;
    localparam logic [AXI_ADDR_W-1:0] REG_SPEED  = 8'h08;
    localparam logic [AXI_ADDR_W-1:0] REG_INIT_X = 8'h0C;
    localparam logic [AXI_ADDR_W-1:0] REG_INIT_Y = 8'h10;
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 8'h14;
    localparam logic [AXI_ADDR_W-1:0] REG_CAR_X  = 8'h18;
    localparam logic [AXI_ADDR_W-1:0] REG_CAR_Y  = 8'h1C;
    localparam logic [1:0]            RESP_OKAY  = 2'b00;

    typedef logic [COORD_W-1:0]  coord_t;   // Grid cell index
    typedef logic [SPEED_W-1:0]  speed_t;   // Cells per tick
    typedef logic [PERIOD_W-1:0] period_t;  // Tick period in clocks

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_PLAY = 2'd1,
        ST_HIT  = 2'd2,
        ST_WIN  = 2'd3
    } game_state_t;

    typedef struct packed {
        logic [CAR_VEC_W-1:0] car_x;
        logic [CAR_VEC_W-1:0] car_y;
    } car_pos_t;

    typedef struct packed {
        logic [SPD_VEC_W-1:0] speed;
        logic [CAR_VEC_W-1:0] init_x;
        logic [CAR_VEC_W-1:0] init_y;
    } car_cfg_t;

    typedef struct packed {
        logic                  awvalid;
        logic [AXI_ADDR_W-1:0] awaddr;
        logic                  wvalid;
        logic [AXI_DATA_W-1:0] wdata;
        logic                  bready;
        logic                  arvalid;
        logic [AXI_ADDR_W-1:0] araddr;
        logic                  rready;
    } axil_req_t;

    typedef struct packed {
        logic                  awready;
        logic                  wready;
        logic                  bvalid;
        logic [1:0]            bresp;
        logic                  arready;
        logic                  rvalid;
        logic [AXI_DATA_W-1:0] rdata;
        logic [1:0]            rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } btn_t;

endpackage

`default_nettype wire

/* source/move_tick.sv */
//**********************************************************
// Programmable slowdown counter, movement tick
//**********************************************************
`default_nettype none

module move_tick import road_pkg::*; (
    input  wire logic        i_Clk,
    input  wire logic        i_arst_n,
    input  wire game_state_t i_state,    // Counting only in ST_PLAY
    input  wire period_t     i_period,   // Tick threshold
    output logic             o_tick      // One cycle every period+1 clocks
);

    period_t r_count;   // Slowdown counter
    logic    w_play;

    assign w_play = (i_state == ST_PLAY);

    // Tick on the terminal count, so it never fires outside play
    assign o_tick = w_play && (r_count >= i_period);

    always_ff @(posedge i_Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_count <= '0;
        end else if (!w_play) begin
            r_count <= '0;                  // Held clear while idle or game over
        end else if (o_tick) begin
            r_count <= '0;                  // Restart after each tick
        end else begin
            r_count <= r_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/car_bank.sv */
//**********************************************************
// Car position registers with start load,
// per-car speed advance and right-edge wrap
//**********************************************************
`default_nettype none

module car_bank import road_pkg::*; (
    input  wire logic     i_Clk,
    input  wire logic     i_arst_n,
    input  wire logic     i_start,    // Load start positions
    input  wire logic     i_tick,     // Advance all cars
    input  wire car_cfg_t i_cfg,      // Speeds and start cells
    output car_pos_t      o_cars      // Packed X and Y, car 0 lowest
);

    coord_t             r_car_x [NUM_CARS];   // Current column per car
    coord_t             r_car_y [NUM_CARS];   // Lane, fixed after load
    coord_t             w_next_x [NUM_CARS];  // Advanced column
    logic [COORD_W:0]   w_sum [NUM_CARS];     // One extra bit so the sum can't overflow
    speed_t             w_speed [NUM_CARS];

    // Next X for every car in parallel
    always_comb begin
        for (int i = 0; i < NUM_CARS; i++) begin
            w_speed[i] = i_cfg.speed[i*SPEED_W +: SPEED_W];
            w_sum[i]   = {1'b0, r_car_x[i]} + {{(COORD_W-SPEED_W+1){1'b0}}, w_speed[i]};
            if (w_sum[i] < GRID_W) begin
                w_next_x[i] = w_sum[i][COORD_W-1:0];
            end else begin
                w_next_x[i] = '0;                    // Wrap back to column 0
            end
        end
    end

    always_ff @(posedge i_Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < NUM_CARS; i++) begin
                r_car_x[i] <= '0;
                r_car_y[i] <= '0;
            end
        end else if (i_start) begin
            // Start wins over a coincident tick
            for (int i = 0; i < NUM_CARS; i++) begin
                r_car_x[i] <= i_cfg.init_x[i*COORD_W +: COORD_W];
                r_car_y[i] <= i_cfg.init_y[i*COORD_W +: COORD_W];
            end
        end else if (i_tick) begin
            for (int i = 0; i < NUM_CARS; i++) begin
                r_car_x[i] <= w_next_x[i];           // Y stays in its lane
            end
        end
    end

    // Flatten the arrays onto the position bus
    always_comb begin
        o_cars = '0;
        for (int i = 0; i < NUM_CARS; i++) begin
            o_cars.car_x[i*COORD_W +: COORD_W] = r_car_x[i];
            o_cars.car_y[i*COORD_W +: COORD_W] = r_car_y[i];
        end
    end

endmodule

`default_nettype wire

/* source/frog_ctrl.sv */
//**********************************************************
// Frog cell register, button moves clamped to the grid
//**********************************************************
`default_nettype none

module frog_ctrl import road_pkg::*; (
    input  wire logic        i_Clk,
    input  wire logic        i_arst_n,
    input  wire logic        i_start,     // Back to the start cell
    input  wire game_state_t i_state,     // Moves only while playing
    input  wire btn_t        i_btn,       // Clean single-cycle pulses
    output coord_t           o_frog_x,
    output coord_t           o_frog_y
);

    coord_t r_x;
    coord_t r_y;
    logic   w_play;

    assign w_play = (i_state == ST_PLAY);

    // Highest-priority button picks the move, an off-grid move is dropped
    always_ff @(posedge i_Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_x <= coord_t'(FROG_START_X);
            r_y <= coord_t'(FROG_START_Y);
        end else if (i_start) begin
            r_x <= coord_t'(FROG_START_X);
            r_y <= coord_t'(FROG_START_Y);
        end else if (w_play) begin
            if (i_btn.up) begin
                if (r_y != '0) begin
                    r_y <= r_y - 1'b1;              // Toward the goal row
                end
            end else if (i_btn.down) begin
                if (r_y < GRID_H - 1) begin
                    r_y <= r_y + 1'b1;
                end
            end else if (i_btn.left) begin
                if (r_x != '0) begin
                    r_x <= r_x - 1'b1;
                end
            end else if (i_btn.right) begin
                if (r_x < GRID_W - 1) begin
                    r_x <= r_x + 1'b1;              // Right edge is GRID_W-1
                end
            end
        end
    end

    assign o_frog_x = r_x;
    assign o_frog_y = r_y;

endmodule

`default_nettype wire

/* source/game_judge.sv */
//**********************************************************
// Game-state FSM with collision and goal detection
//**********************************************************
`default_nettype none

module game_judge import road_pkg::*; (
    input  wire logic     i_Clk,
    input  wire logic     i_arst_n,
    input  wire logic     i_start,    // Any state to ST_PLAY
    input  wire car_pos_t i_cars,
    input  wire coord_t   i_frog_x,
    input  wire coord_t   i_frog_y,
    output game_state_t   o_state
);

    game_state_t r_state;
    game_state_t w_next;
    logic        w_hit;     // Frog shares a cell with some car
    logic        w_goal;    // Frog on the goal row

    // Compare frog cell against every car at once
    always_comb begin
        w_hit = 1'b0;
        for (int i = 0; i < NUM_CARS; i++) begin
            if ((i_cars.car_x[i*COORD_W +: COORD_W] == i_frog_x) &&
                (i_cars.car_y[i*COORD_W +: COORD_W] == i_frog_y)) begin
                w_hit = 1'b1;
            end
        end
    end

    assign w_goal = (i_frog_y == coord_t'(GOAL_ROW));

    always_comb begin
        w_next = r_state;
        if (i_start) begin
            w_next = ST_PLAY;
        end else if (r_state == ST_PLAY) begin
            if (w_hit) begin
                w_next = ST_HIT;             // Hit beats goal
            end else if (w_goal) begin
                w_next = ST_WIN;
            end
        end
        // ST_IDLE, ST_HIT and ST_WIN wait for start
    end

    always_ff @(posedge i_Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_state <= ST_IDLE;
        end else begin
            r_state <= w_next;
        end
    end

    assign o_state = r_state;

endmodule

`default_nettype wire

/* source/axil_regs.sv */
//**********************************************************
// AXI4-Lite slave, game config registers,
// start pulse and status and position readback
//**********************************************************
`default_nettype none

module axil_regs import road_pkg::*; (
    input  wire logic        i_Clk,
    input  wire logic        i_arst_n,
    input  wire axil_req_t   i_axil,
    output axil_rsp_t        o_axil,
    output car_cfg_t         o_cfg,       // Speeds and start cells
    output period_t          o_period,    // Tick period
    output logic             o_start,     // Pulse after a CTRL write with bit 0
    input  wire car_pos_t    i_cars,
    input  wire coord_t      i_frog_x,
    input  wire coord_t      i_frog_y,
    input  wire game_state_t i_state
);

    period_t                r_period;
    logic [SPD_VEC_W-1:0]   r_speed;
    logic [CAR_VEC_W-1:0]   r_init_x;
    logic [CAR_VEC_W-1:0]   r_init_y;
    logic                   r_start;
    logic                   r_bvalid;
    logic                   r_rvalid;
    logic [AXI_DATA_W-1:0]  r_rdata;
    logic [AXI_DATA_W-1:0]  w_rd_mux;   // Readback selected by araddr
    logic                   w_wr_en;    // AW and W taken together
    logic                   w_rd_en;

    // Pending B or R response blocks the next transfer
    assign w_wr_en = i_axil.awvalid && i_axil.wvalid && !r_bvalid;
    assign w_rd_en = i_axil.arvalid && !r_rvalid;

    // Write channel and config registers
    always_ff @(posedge i_Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_period <= period_t'(PERIOD_RESET);
            r_speed  <= '0;
            r_init_x <= '0;
            r_init_y <= '0;
            r_start  <= 1'b0;
            r_bvalid <= 1'b0;
        end else begin
            r_start <= 1'b0;                               // Single-cycle pulse
            if (w_wr_en) begin
                r_bvalid <= 1'b1;
                case (i_axil.awaddr)
                    REG_CTRL:   r_start  <= i_axil.wdata[0];
                    REG_PERIOD: r_period <= i_axil.wdata[PERIOD_W-1:0];
                    REG_SPEED:  r_speed  <= i_axil.wdata[SPD_VEC_W-1:0];
                    REG_INIT_X: r_init_x <= i_axil.wdata[CAR_VEC_W-1:0];
                    REG_INIT_Y: r_init_y <= i_axil.wdata[CAR_VEC_W-1:0];
                    default: ;                             // Read-only or unmapped
                endcase
            end else if (r_bvalid && i_axil.bready) begin
                r_bvalid <= 1'b0;
            end
        end
    end

    // Readback mux
    always_comb begin
        w_rd_mux = '0;                                     // Unmapped reads as zero
        case (i_axil.araddr)
            REG_PERIOD: w_rd_mux[PERIOD_W-1:0]  = r_period;
            REG_SPEED:  w_rd_mux[SPD_VEC_W-1:0] = r_speed;
            REG_INIT_X: w_rd_mux[CAR_VEC_W-1:0] = r_init_x;
            REG_INIT_Y: w_rd_mux[CAR_VEC_W-1:0] = r_init_y;
            REG_STATUS: begin
                w_rd_mux[1:0]   = i_state;
                w_rd_mux[13:8]  = i_frog_x;
                w_rd_mux[21:16] = i_frog_y;
            end
            REG_CAR_X:  w_rd_mux[CAR_VEC_W-1:0] = i_cars.car_x;
            REG_CAR_Y:  w_rd_mux[CAR_VEC_W-1:0] = i_cars.car_y;
            default: ;
        endcase
    end

    // Read response valid
    always_ff @(posedge i_Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_rvalid <= 1'b0;
        end else if (w_rd_en) begin
            r_rvalid <= 1'b1;
        end else if (r_rvalid && i_axil.rready) begin
            r_rvalid <= 1'b0;
        end
    end

    // Read data captured on acceptance, held until rready
    always_ff @(posedge i_Clk) begin
        if (w_rd_en) begin
            r_rdata <= w_rd_mux;
        end
    end

    always_comb begin
        o_axil         = '0;
        o_axil.awready = w_wr_en;
        o_axil.wready  = w_wr_en;
        o_axil.bvalid  = r_bvalid;
        o_axil.bresp   = RESP_OKAY;
        o_axil.arready = w_rd_en;
        o_axil.rvalid  = r_rvalid;
        o_axil.rdata   = r_rdata;
        o_axil.rresp   = RESP_OKAY;
    end

    assign o_cfg.speed  = r_speed;
    assign o_cfg.init_x = r_init_x;
    assign o_cfg.init_y = r_init_y;
    assign o_period     = r_period;
    assign o_start      = r_start;

endmodule

`default_nettype wire

/* source/road_top.sv */
//**********************************************************
// Game core top, register block, tick, cars, frog, judge
//**********************************************************
`default_nettype none

module road_top import road_pkg::*; (
    input  wire logic      i_Clk,
    input  wire logic      i_arst_n,
    input  wire axil_req_t i_axil,      // Host bus
    output axil_rsp_t      o_axil,
    input  wire btn_t      i_btn,       // Button pulses
    output car_pos_t       o_cars,      // To the display
    output coord_t         o_frog_x,
    output coord_t         o_frog_y,
    output game_state_t    o_state
);

    car_cfg_t    w_cfg;
    period_t     w_period;
    logic        w_start;
    logic        w_tick;

    axil_regs i_axil_regs (
        .i_Clk    (i_Clk),
        .i_arst_n (i_arst_n),
        .i_axil   (i_axil),
        .o_axil   (o_axil),
        .o_cfg    (w_cfg),
        .o_period (w_period),
        .o_start  (w_start),
        .i_cars   (o_cars),
        .i_frog_x (o_frog_x),
        .i_frog_y (o_frog_y),
        .i_state  (o_state)
    );

    move_tick i_move_tick (
        .i_Clk    (i_Clk),
        .i_arst_n (i_arst_n),
        .i_state  (o_state),
        .i_period (w_period),
        .o_tick   (w_tick)
    );

    car_bank i_car_bank (
        .i_Clk    (i_Clk),
        .i_arst_n (i_arst_n),
        .i_start  (w_start),
        .i_tick   (w_tick),
        .i_cfg    (w_cfg),
        .o_cars   (o_cars)
    );

    frog_ctrl i_frog_ctrl (
        .i_Clk    (i_Clk),
        .i_arst_n (i_arst_n),
        .i_start  (w_start),
        .i_state  (o_state),
        .i_btn    (i_btn),
        .o_frog_x (o_frog_x),
        .o_frog_y (o_frog_y)
    );

    game_judge i_game_judge (
        .i_Clk    (i_Clk),
        .i_arst_n (i_arst_n),
        .i_start  (w_start),
        .i_cars   (o_cars),
        .i_frog_x (o_frog_x),
        .i_frog_y (o_frog_y),
        .o_state  (o_state)
    );

endmodule

`default_nettype wire

/* dv/road_checker.sv */
//**********************************************************
// Testbench checker, car motion against the advance rule,
// frog, state and bus readback comparisons
//**********************************************************
`default_nettype none

module road_checker import road_pkg::*; (
    input  wire logic                 i_Clk,
    input  wire car_pos_t             i_cars,
    input  wire coord_t               i_frog_x,
    input  wire coord_t               i_frog_y,
    input  wire game_state_t          i_state,
    input  wire logic [SPD_VEC_W-1:0] i_speed,       // Speeds the host wrote
    input  wire logic                 i_motion_en,   // Watch car changes
    output int                        o_errors,
    output int                        o_changes      // Car bus changes seen
);

    timeunit 1ns;
    timeprecision 1ps;

    int       errors  = 0;
    int       changes = 0;
    car_pos_t prev;          // Car bus one sample back

    assign o_errors  = errors;
    assign o_changes = changes;

    // Expected column after one tick
    function automatic coord_t next_car_x(coord_t x, speed_t s);
        int sum;
        sum = int'(x) + int'(s);
        if (sum < GRID_W) begin
            return coord_t'(sum);
        end
        return '0;                                   // Past the right edge
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(string what);
        errors++;
        $display("failure at %0t ns: %s", $time, what);
    endtask

    task automatic check_frog(coord_t ex, coord_t ey);
        check_value("o_frog_x", 32'(i_frog_x), 32'(ex));
        check_value("o_frog_y", 32'(i_frog_y), 32'(ey));
    endtask

    task automatic check_state(game_state_t es);
        check_value("o_state", 32'(i_state), 32'(es));
    endtask

    task automatic check_cars(logic [CAR_VEC_W-1:0] ex, logic [CAR_VEC_W-1:0] ey);
        check_value("o_cars.car_x", 32'(i_cars.car_x), 32'(ex));
        check_value("o_cars.car_y", 32'(i_cars.car_y), 32'(ey));
    endtask

    // Each change of the car bus must be exactly one advance
    always @(negedge i_Clk) begin
        if (i_motion_en && (i_cars != prev)) begin
            changes++;
            for (int i = 0; i < NUM_CARS; i++) begin
                check_value($sformatf("o_cars.car_x[%0d]", i),
                            32'(i_cars.car_x[i*COORD_W +: COORD_W]),
                            32'(next_car_x(prev.car_x[i*COORD_W +: COORD_W],
                                           i_speed[i*SPEED_W +: SPEED_W])));
            end
            check_value("o_cars.car_y", 32'(i_cars.car_y), 32'(prev.car_y));  // Lanes fixed
        end
        prev = i_cars;
    end

endmodule

`default_nettype wire

/* dv/road_tb.sv */
//**********************************************************
// Testbench top, clock and reset, AXI4-Lite and button
// stimulus, reference model, watchdog and summary
//**********************************************************
`default_nettype none

module road_tb import road_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_NS      = 40;
    localparam int DRIVE_NS    = 2;        // Skew after the rising edge
    localparam int RST_CYCLES  = 16;
    localparam int PLAY_PERIOD = 3;
    localparam int MIN_CHANGES = 25;
    // Run length from ticks, bus accesses and button pulses
    localparam int N_TICKS     = MIN_CHANGES + 20;
    localparam int N_ACCESS    = 40;
    localparam int N_PULSES    = 110;
    localparam int RUN_CYCLES  = RST_CYCLES + N_TICKS * (PLAY_PERIOD + 1) +
                                 N_ACCESS * 5 + N_PULSES * 3 + 60;
    localparam int WATCHDOG_NS = 2 * RUN_CYCLES * CLK_NS;   // Twice the budget

    localparam btn_t B_UP    = 4'b1000;
    localparam btn_t B_DOWN  = 4'b0100;
    localparam btn_t B_LEFT  = 4'b0010;
    localparam btn_t B_RIGHT = 4'b0001;

    logic                 clk = 1'b0;
    logic                 arst_n;
    axil_req_t            axil_req;
    axil_rsp_t            axil_rsp;
    btn_t                 btn;
    car_pos_t             cars;
    coord_t               frog_x;
    coord_t               frog_y;
    game_state_t          state;
    logic [SPD_VEC_W-1:0] exp_speed;
    logic [CAR_VEC_W-1:0] init_x;      // Start cells last written
    logic [CAR_VEC_W-1:0] init_y;
    logic                 motion_en;
    int                   errors;
    int                   changes;
    int                   change_base;
    integer               seed = 32'hfc66;
    int                   tests_run = 0;
    int                   tests_failed = 0;
    int                   test_base = 0;   // Error count at test start
    coord_t               ex_x;            // Predicted frog cell
    coord_t               ex_y;

    always #(CLK_NS / 2) clk = ~clk;

    road_top i_road_top (
        .i_Clk    (clk),
        .i_arst_n (arst_n),
        .i_axil   (axil_req),
        .o_axil   (axil_rsp),
        .i_btn    (btn),
        .o_cars   (cars),
        .o_frog_x (frog_x),
        .o_frog_y (frog_y),
        .o_state  (state)
    );

    road_checker i_road_checker (
        .i_Clk       (clk),
        .i_cars      (cars),
        .i_frog_x    (frog_x),
        .i_frog_y    (frog_y),
        .i_state     (state),
        .i_speed     (exp_speed),
        .i_motion_en (motion_en),
        .o_errors    (errors),
        .o_changes   (changes)
    );

    // Frog cell after one pulse, off-grid moves dropped
    function automatic logic [11:0] frog_move(coord_t x, coord_t y, btn_t b);
        int nx;
        int ny;
        nx = x;
        ny = y;
        if (b.up) begin
            ny = ny - 1;
        end else if (b.down) begin
            ny = ny + 1;
        end else if (b.left) begin
            nx = nx - 1;
        end else if (b.right) begin
            nx = nx + 1;
        end
        if (nx < 0 || nx >= GRID_W || ny < 0 || ny >= GRID_H) begin
            return {x, y};
        end
        return {coord_t'(nx), coord_t'(ny)};
    endfunction

    // STATUS layout, state 1:0, X 13:8, Y 21:16
    function automatic logic [31:0] status_word(game_state_t st, coord_t x, coord_t y);
        logic [31:0] word;
        word        = '0;
        word[1:0]   = st;
        word[13:8]  = x;
        word[21:16] = y;
        return word;
    endfunction

    task automatic axil_write(logic [7:0] addr, logic [31:0] data);
        @(posedge clk);
        #DRIVE_NS;
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.bready  = 1'b1;
        do begin
            @(negedge clk);
        end while (!axil_rsp.awready);
        i_road_checker.check_value("wready", 32'(axil_rsp.wready), 32'h1);
        @(posedge clk);                                     // Accepted here
        #DRIVE_NS;
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        while (!axil_rsp.bvalid) begin
            @(negedge clk);
        end
        i_road_checker.check_value("bresp", 32'(axil_rsp.bresp), 32'(RESP_OKAY));
        @(posedge clk);
        #DRIVE_NS;
        axil_req.bready = 1'b0;
    endtask

    task automatic read_check(string name, logic [7:0] addr, logic [31:0] exp);
        @(posedge clk);
        #DRIVE_NS;
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        axil_req.rready  = 1'b1;
        do begin
            @(negedge clk);
        end while (!axil_rsp.arready);
        @(posedge clk);
        #DRIVE_NS;
        axil_req.arvalid = 1'b0;
        if (!axil_rsp.rvalid) begin
            i_road_checker.report_failure("read response did not arrive after arready");
        end
        i_road_checker.check_value(name, axil_rsp.rdata, exp);
        i_road_checker.check_value("rresp", 32'(axil_rsp.rresp), 32'(RESP_OKAY));
        @(posedge clk);
        #DRIVE_NS;
        axil_req.rready = 1'b0;
    endtask

    task automatic round_trip(string name, logic [7:0] addr, logic [31:0] mask);
        logic [31:0] data;
        data = $random(seed);
        axil_write(addr, data);
        read_check(name, addr, data & mask);               // Unused upper bits read zero
    endtask

    task automatic load_config(logic [SPD_VEC_W-1:0] spd, logic [CAR_VEC_W-1:0] ix,
                               logic [CAR_VEC_W-1:0] iy);
        exp_speed = spd;
        init_x    = ix;
        init_y    = iy;
        axil_write(REG_SPEED, 32'(spd));
        axil_write(REG_INIT_X, 32'(ix));
        axil_write(REG_INIT_Y, 32'(iy));
    endtask

    // Start, then expect a fresh game with everything reloaded
    task automatic start_game();
        axil_write(REG_CTRL, 32'h1);
        @(negedge clk);
        ex_x = coord_t'(FROG_START_X);
        ex_y = coord_t'(FROG_START_Y);
        i_road_checker.check_state(ST_PLAY);
        i_road_checker.check_cars(init_x, init_y);
        i_road_checker.check_frog(ex_x, ex_y);
    endtask

    task automatic press(btn_t b);
        @(posedge clk);
        #DRIVE_NS;
        btn = b;
        @(posedge clk);                                     // Frog moves here
        #DRIVE_NS;
        btn = '0;
        @(negedge clk);
    endtask

    task automatic move_frog(btn_t b);
        press(b);
        {ex_x, ex_y} = frog_move(ex_x, ex_y, b);
        i_road_checker.check_frog(ex_x, ex_y);
    endtask

    task automatic wait_state(game_state_t st, int max_cycles);
        int n;
        n = 0;
        while (state != st && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (state != st) begin
            i_road_checker.report_failure($sformatf("state %s not reached in %0d cycles",
                                                    st.name(), max_cycles));
        end
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (errors != test_base) begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name, errors - test_base);
        end else begin
            $display("test %0d %s: passed", tests_run, name);
        end
        test_base = errors;
    endtask

    initial begin
        logic [SPD_VEC_W-1:0] spd;
        logic [CAR_VEC_W-1:0] ix;
        logic [CAR_VEC_W-1:0] iy;
        arst_n    = 1'b0;
        axil_req  = '0;
        btn       = '0;
        motion_en = 1'b0;
        exp_speed = '0;
        init_x    = '0;
        init_y    = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_NS;
        arst_n = 1'b1;

        read_check("status", REG_STATUS,
                   status_word(ST_IDLE, coord_t'(FROG_START_X), coord_t'(FROG_START_Y)));
        read_check("period", REG_PERIOD, 32'(PERIOD_RESET));
        round_trip("period", REG_PERIOD, 32'h00ff_ffff);
        round_trip("speed", REG_SPEED, 32'h0000_00ff);
        round_trip("init_x", REG_INIT_X, 32'h00ff_ffff);
        round_trip("init_y", REG_INIT_Y, 32'h00ff_ffff);
        read_check("unmapped", 8'h20, 32'h0);              // Past the last register
        end_test("reset and register round trip");

        // Random lanes 1..14 keep clear of the parked frog
        axil_write(REG_PERIOD, 32'(PLAY_PERIOD));
        spd      = $random(seed);
        spd[1:0] = speed_t'(1 + $unsigned($random(seed)) % 3);   // Car 0 always moves
        for (int i = 0; i < NUM_CARS; i++) begin
            ix[i*COORD_W +: COORD_W] = coord_t'($unsigned($random(seed)) % GRID_W);
            iy[i*COORD_W +: COORD_W] = coord_t'(1 + $unsigned($random(seed)) % (GRID_H - 2));
        end
        load_config(spd, ix, iy);
        start_game();
        @(posedge clk);
        #DRIVE_NS;
        motion_en   = 1'b1;
        change_base = changes;
        while (changes < change_base + MIN_CHANGES) begin
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_NS;
        motion_en = 1'b0;
        end_test("car motion");

        // Parked cars in rows 1 and 2, out of the frog's reach
        load_config('0, {6'd30, 6'd25, 6'd8, 6'd3}, {6'd2, 6'd1, 6'd2, 6'd1});
        start_game();
        move_frog(B_DOWN);                                  // Bottom edge
        repeat (GRID_W - FROG_START_X) begin
            move_frog(B_RIGHT);                             // Last one hits the right edge
        end
        read_check("status", REG_STATUS, status_word(ST_PLAY, ex_x, ex_y));
        repeat (GRID_W + 1) begin
            move_frog(B_LEFT);
        end
        read_check("status", REG_STATUS, status_word(ST_PLAY, ex_x, ex_y));
        repeat (12) begin
            move_frog(btn_t'($random(seed)));               // Mixed presses test priority
        end
        read_check("status", REG_STATUS, status_word(ST_PLAY, ex_x, ex_y));
        end_test("frog movement");

        // Car 0 drives along row 15 into the waiting frog
        load_config(8'h01, {6'd32, 6'd31, 6'd30, 6'd10}, {6'd3, 6'd2, 6'd1, 6'd15});
        start_game();
        wait_state(ST_HIT, GRID_W * (PLAY_PERIOD + 1));
        i_road_checker.check_cars({6'd32, 6'd31, 6'd30, 6'd20}, init_y);
        read_check("car_x", REG_CAR_X, 32'({6'd32, 6'd31, 6'd30, 6'd20}));
        read_check("car_y", REG_CAR_Y, 32'(init_y));
        press(B_LEFT);
        press(B_UP);
        repeat (5 * (PLAY_PERIOD + 1)) @(negedge clk);
        i_road_checker.check_cars({6'd32, 6'd31, 6'd30, 6'd20}, init_y);  // Frozen
        i_road_checker.check_frog(ex_x, ex_y);
        i_road_checker.check_state(ST_HIT);
        end_test("collision");

        // Restart from ST_HIT, then climb column 20 to the goal
        load_config('0, {6'd4, 6'd3, 6'd2, 6'd1}, {6'd8, 6'd7, 6'd6, 6'd5});
        start_game();
        repeat (FROG_START_Y - GOAL_ROW) begin
            move_frog(B_UP);
        end
        wait_state(ST_WIN, 4);
        read_check("status", REG_STATUS, status_word(ST_WIN, ex_x, ex_y));
        end_test("goal");

        start_game();                                       // Restart from ST_WIN
        end_test("restart");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
source/road_pkg.sv
source/move_tick.sv
source/car_bank.sv
source/frog_ctrl.sv
source/game_judge.sv
source/axil_regs.sv
source/road_top.sv
dv/road_checker.sv
dv/road_tb.sv

/* Makefile */
# Verilator build and run of the game core testbench

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f tb.f --top-module road_tb
	@out="$$(./obj_dir/Vroad_tb)"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
